/* Makefile */
# Verilator build and run for the display subsystem testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, pass only if the log shows a pass"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -f vlog.f --top-module tb_hex_display \
		-Mdir obj_dir -o tb_hex_display
	./obj_dir/tb_hex_display | tee $(LOG)
	@grep -qx "TB PASSED" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf obj_dir $(LOG)

/* design/hex_display_top.sv */
// Display subsystem top with register file, six segment decoders and registered pin drive
`timescale 1ns/1ps
`default_nettype none

module hex_display_top (
  input  logic                         clk,
  input  logic                         rst,
  input  hex_pkg::bus_req_t            bus,
  output logic [hex_pkg::DATA_W-1:0]   readdata,
  output hex_pkg::hex_out_t            hex,
  output logic [hex_pkg::NUM_LEDS-1:0] ledr
);

  import hex_pkg::*;

  // Register file view
  disp_state_t state;

  // Decoder outputs ahead of the pin registers
  hex_out_t seg_next;

  // ====================
  // Register file
  // ====================

  hex_regs u_regs (
    .clk      (clk),
    .rst      (rst),
    .bus      (bus),
    .readdata (readdata),
    .state    (state)
  );

  // ====================
  // Decoders
  // ====================

  // One decoder per display, digit i drives HEXi
  for (genvar i = 0; i < NUM_DIGITS; i++) begin : g_digit
    seg_decoder u_dec (
      .digit (state.digits[i]),
      .blank (state.blank[i]),
      .seg   (seg_next[i])
    );
  end

  // ====================
  // Pin registers
  // ====================

  // Glitch-free drive for off-chip segments and LEDs
  // One cycle behind the register file
  always_ff @(posedge clk) begin
    if (rst) begin
      hex  <= {NUM_DIGITS{SEG_OFF}};
      ledr <= '0;
    end else begin
      hex  <= seg_next;
      ledr <= state.led;
    end
  end

  // ====================
  // Checks
  // ====================

  // Blank bit set one cycle ago means that digit is dark now
  for (genvar i = 0; i < NUM_DIGITS; i++) begin : g_blank_chk
    a_blank_dark: assert property (
      @(posedge clk) disable iff (rst) $past(state.blank[i]) |-> (hex[i] == SEG_OFF)
    ) else $error("hex digit %0d lit while blanked", i);
  end

endmodule

`default_nettype wire

/* design/hex_pkg.sv */
// Display subsystem package with register map, bus request and display types
`default_nettype none

package hex_pkg;

  // ====================
  // Board dimensions
  // ====================

  // Six seven-segment displays on the board
  localparam int NUM_DIGITS = 6;
  // Red LED bank width
  localparam int NUM_LEDS = 10;
  // Width of one hex digit
  localparam int DIGIT_W = 4;
  // Segments a through g
  localparam int SEG_W = 7;

  // ====================
  // Host bus
  // ====================

  localparam int ADDR_W = 3;
  localparam int DATA_W = 16;

  // Register map
  // Addresses 0 to 5 hold digits 0 to 5
  localparam logic [ADDR_W-1:0] ADDR_BLANK = 3'd6;
  localparam logic [ADDR_W-1:0] ADDR_LED   = 3'd7;

  // ====================
  // Display types
  // ====================

  // One hexadecimal digit value
  typedef logic [DIGIT_W-1:0] digit_t;

  // Active low, bit 0 is segment a, bit 6 is segment g
  typedef logic [SEG_W-1:0] seg_t;

  // Every segment dark
  localparam seg_t SEG_OFF = 7'h7f;

  // Single-cycle strobes, never both high
  typedef struct packed {
    logic              write;
    logic              read;
    logic [ADDR_W-1:0] address;
    logic [DATA_W-1:0] writedata;
  } bus_req_t;

  // Register file contents seen by the display path
  typedef struct packed {
    digit_t [NUM_DIGITS-1:0] digits;
    logic [NUM_DIGITS-1:0]   blank;
    logic [NUM_LEDS-1:0]     led;
  } disp_state_t;

  // All six HEX outputs side by side, digit 0 in the low bits
  typedef seg_t [NUM_DIGITS-1:0] hex_out_t;

endpackage

`default_nettype wire

/* design/hex_regs.sv */
// Bus-addressed register file for six hex digits, blank mask and LEDs with registered read-back
`timescale 1ns/1ps
`default_nettype none

module hex_regs (
  input  logic                       clk,
  input  logic                       rst,
  input  hex_pkg::bus_req_t          bus,
  output logic [hex_pkg::DATA_W-1:0] readdata,
  output hex_pkg::disp_state_t       state
);

  import hex_pkg::*;

  // Storage
  digit_t [NUM_DIGITS-1:0] digit_q;
  logic [NUM_DIGITS-1:0]   blank_q;
  logic [NUM_LEDS-1:0]     led_q;

  // Address decode
  logic                  addr_is_digit;
  logic                  addr_is_blank;
  logic                  addr_is_led;
  logic [NUM_DIGITS-1:0] digit_sel;

  // Read mux before the readdata register
  logic [DATA_W-1:0] rd_mux;

  // ====================
  // Address decode
  // ====================

  // One-hot digit select, all zero for addresses 6 and 7
  always_comb begin
    digit_sel = '0;
    for (int i = 0; i < NUM_DIGITS; i++) begin
      if (bus.address == ADDR_W'(i)) begin
        digit_sel[i] = 1'b1;
      end
    end
  end

  assign addr_is_digit = |digit_sel;
  assign addr_is_blank = (bus.address == ADDR_BLANK);
  assign addr_is_led   = (bus.address == ADDR_LED);

  // ====================
  // Write path
  // ====================

  // Upper writedata bits are dropped
  always_ff @(posedge clk) begin
    if (rst) begin
      digit_q <= '0;
      // Display starts dark
      blank_q <= '1;
      led_q   <= '0;
    end else if (bus.write) begin
      for (int i = 0; i < NUM_DIGITS; i++) begin
        if (digit_sel[i]) begin
          digit_q[i] <= bus.writedata[DIGIT_W-1:0];
        end
      end
      if (addr_is_blank) begin
        blank_q <= bus.writedata[NUM_DIGITS-1:0];
      end
      if (addr_is_led) begin
        led_q <= bus.writedata[NUM_LEDS-1:0];
      end
    end
  end

  // ====================
  // Read path
  // ====================

  // Zero-extended, same bit positions as the write
  always_comb begin
    rd_mux = '0;
    if (addr_is_digit) begin
      for (int i = 0; i < NUM_DIGITS; i++) begin
        if (digit_sel[i]) begin
          rd_mux[DIGIT_W-1:0] = digit_q[i];
        end
      end
    end else if (addr_is_blank) begin
      rd_mux[NUM_DIGITS-1:0] = blank_q;
    end else if (addr_is_led) begin
      rd_mux[NUM_LEDS-1:0] = led_q;
    end
  end

  // Holds the last read value until the next read
  always_ff @(posedge clk) begin
    if (rst) begin
      readdata <= '0;
    end else if (bus.read) begin
      readdata <= rd_mux;
    end
  end

  // Straight from the registers, no extra stage
  assign state.digits = digit_q;
  assign state.blank  = blank_q;
  assign state.led    = led_q;

  // ====================
  // Checks
  // ====================

  // Host never issues read and write together
  a_no_rw_overlap: assert property (
    @(posedge clk) disable iff (rst) !(bus.read && bus.write)
  ) else $error("hex_regs read and write strobes high together");

  // Host stays quiet during reset
  a_quiet_in_reset: assert property (
    @(posedge clk) rst |-> !(bus.read || bus.write)
  ) else $error("hex_regs bus strobe seen during reset");

endmodule

`default_nettype wire

/* design/seg_decoder.sv */
// Seven-segment decoder turning one hex nibble and a blank flag into active-low segments
`timescale 1ns/1ps
`default_nettype none

module seg_decoder (
  input  hex_pkg::digit_t digit,
  input  logic            blank,
  output hex_pkg::seg_t   seg
);

  import hex_pkg::*;

  // Active-high pattern before inversion
  seg_t lit;

  // ====================
  // Glyph table
  // ====================

  // Bit order gfedcba
  always_comb begin
    case (digit)
      4'h0: lit = 7'b0111111;
      4'h1: lit = 7'b0000110;
      4'h2: lit = 7'b1011011;
      4'h3: lit = 7'b1001111;
      4'h4: lit = 7'b1100110;
      4'h5: lit = 7'b1101101;
      4'h6: lit = 7'b1111101;
      4'h7: lit = 7'b0000111;
      4'h8: lit = 7'b1111111;
      4'h9: lit = 7'b1101111;
      // Upper-case A
      4'ha: lit = 7'b1110111;
      // Lower-case b, upper-case B would look like 8
      4'hb: lit = 7'b1111100;
      4'hc: lit = 7'b0111001;
      // Lower-case d, upper-case D would look like 0
      4'hd: lit = 7'b1011110;
      4'he: lit = 7'b1111001;
      4'hf: lit = 7'b1110001;
      default: lit = '0;
    endcase
  end

  // ====================
  // Output
  // ====================

  // Board segments are active low
  // Blank wins over any digit value
  assign seg = blank ? SEG_OFF : ~lit;

endmodule

`default_nettype wire

/* include/hex_tb_vectors.svh */
// Display testbench vector table with bus operations and expected read values
`ifndef HEX_TB_VECTORS_SVH
`define HEX_TB_VECTORS_SVH

// Columns: op, address, writedata, expected readdata (used on reads only)

localparam logic [1:0] OP_IDLE  = 2'd0;
localparam logic [1:0] OP_WRITE = 2'd1;
localparam logic [1:0] OP_READ  = 2'd2;

typedef struct packed {
  logic [1:0]        op;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] data;
  logic [DATA_W-1:0] exp_read;
} vec_t;

localparam int NUM_VECS = 18;

localparam vec_t VECTORS [NUM_VECS] = '{
  '{OP_WRITE, 3'd6, 16'h0000, 16'h0000},  // unblank every digit
  '{OP_WRITE, 3'd0, 16'hfff3, 16'h0000},  // upper bits dropped
  '{OP_WRITE, 3'd1, 16'h000a, 16'h0000},
  '{OP_WRITE, 3'd7, 16'hfc55, 16'h0000},  // LEDs keep bits 9:0
  '{OP_READ,  3'd0, 16'h0000, 16'h0003},
  '{OP_READ,  3'd1, 16'h0000, 16'h000a},
  '{OP_READ,  3'd7, 16'h0000, 16'h0055},
  '{OP_WRITE, 3'd6, 16'h0015, 16'h0000},  // blank digits 0, 2 and 4
  '{OP_IDLE,  3'd0, 16'h0000, 16'h0000},
  '{OP_READ,  3'd6, 16'h0000, 16'h0015},
  '{OP_WRITE, 3'd6, 16'hffc0, 16'h0000},  // mask bits all clear
  '{OP_READ,  3'd6, 16'h0000, 16'h0000},
  '{OP_WRITE, 3'd5, 16'h000d, 16'h0000},
  '{OP_READ,  3'd5, 16'h0000, 16'h000d},
  '{OP_READ,  3'd2, 16'h0000, 16'h0000},
  '{OP_WRITE, 3'd7, 16'h03ff, 16'h0000},
  '{OP_READ,  3'd7, 16'h0000, 16'h03ff},
  '{OP_IDLE,  3'd0, 16'h0000, 16'h0000}
};

`endif

/* verif/tb_hex_display.sv */
// Testbench for the display subsystem, table-driven bus traffic checked against a register model
`timescale 1ns/1ps
`default_nettype none

module tb_hex_display;

  import hex_pkg::*;

  `include "hex_tb_vectors.svh"

  localparam int RST_CYCLES = 4;
  localparam int MAX_CYCLES = 1000;
  localparam int NUM_RANDOM = 24;

  // Active-low glyphs for 0 to F in bit order gfedcba
  localparam seg_t SEG_TABLE [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e
  };

  logic                clk = 1'b0;
  logic                rst;
  bus_req_t            bus;
  logic [DATA_W-1:0]   readdata;
  hex_out_t            hex;
  logic [NUM_LEDS-1:0] ledr;

  // Register model
  digit_t                mdl_digit [NUM_DIGITS];
  logic [NUM_DIGITS-1:0] mdl_blank;
  logic [NUM_LEDS-1:0]   mdl_led;
  // Held read value
  logic [DATA_W-1:0]     exp_rd;

  // Entry the DUT samples on the coming edge
  vec_t pend;

  int err_count;

  always #20 clk = ~clk;

  hex_display_top u_dut (
    .clk      (clk),
    .rst      (rst),
    .bus      (bus),
    .readdata (readdata),
    .hex      (hex),
    .ledr     (ledr)
  );

  // ====================
  // Model
  // ====================

  function automatic hex_out_t model_hex();
    hex_out_t h;
    for (int i = 0; i < NUM_DIGITS; i++) begin
      h[i] = mdl_blank[i] ? SEG_OFF : SEG_TABLE[mdl_digit[i]];
    end
    return h;
  endfunction

  // Zero-extended register value at its write position
  function automatic logic [DATA_W-1:0] model_read(input logic [ADDR_W-1:0] addr);
    logic [DATA_W-1:0] val;
    val = '0;
    if (addr == ADDR_LED) begin
      val[NUM_LEDS-1:0] = mdl_led;
    end else if (addr == ADDR_BLANK) begin
      val[NUM_DIGITS-1:0] = mdl_blank;
    end else begin
      val[3:0] = mdl_digit[addr];
    end
    return val;
  endfunction

  // Fold the entry the DUT just took into the model
  task automatic retire_pending();
    if (pend.op == OP_WRITE) begin
      if (pend.addr == ADDR_LED) begin
        mdl_led = pend.data[NUM_LEDS-1:0];
      end else if (pend.addr == ADDR_BLANK) begin
        mdl_blank = pend.data[NUM_DIGITS-1:0];
      end else begin
        mdl_digit[pend.addr] = pend.data[3:0];
      end
    end else if (pend.op == OP_READ) begin
      exp_rd = pend.exp_read;
    end
  endtask

  // ====================
  // Compare tasks
  // ====================

  task automatic check_hex(input hex_out_t exp, input hex_out_t act);
    if (act !== exp) begin
      err_count++;
      $display("[ERROR] %0t: hex expected %h, got %h", $time, exp, act);
    end
  endtask

  task automatic check_read(input logic [DATA_W-1:0] exp, input logic [DATA_W-1:0] act);
    if (act !== exp) begin
      err_count++;
      $display("[ERROR] %0t: readdata expected %h, got %h", $time, exp, act);
    end
  endtask

  task automatic check_leds(input logic [NUM_LEDS-1:0] exp, input logic [NUM_LEDS-1:0] act);
    if (act !== exp) begin
      err_count++;
      $display("[ERROR] %0t: ledr expected %h, got %h", $time, exp, act);
    end
  endtask

  // One entry per cycle with the previous entry's results checked at the falling edge
  task automatic apply_entry(input logic [1:0] op, input logic [ADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] data, input logic [DATA_W-1:0] exp_read);
    bus_req_t req;
    req.write     = (op == OP_WRITE);
    req.read      = (op == OP_READ);
    req.address   = addr;
    req.writedata = data;
    @(posedge clk);
    bus <= req;
    @(negedge clk);
    // Pins still show the state before the retiring entry
    check_hex(model_hex(), hex);
    check_leds(mdl_led, ledr);
    retire_pending();
    check_read(exp_rd, readdata);
    pend.op       = op;
    pend.addr     = addr;
    pend.data     = data;
    pend.exp_read = exp_read;
  endtask

  // ====================
  // Stimulus
  // ====================

  initial begin : watchdog
    for (int i = 0; i < MAX_CYCLES; i++) begin
      @(posedge clk);
    end
    $display("Timeout: test did not finish within %0d cycles", MAX_CYCLES);
    $display("TB FAILED");
    $finish;
  end

  initial begin : main
    void'($urandom(28782));
    err_count = 0;
    rst <= 1'b1;
    bus <= '0;
    for (int i = 0; i < RST_CYCLES; i++) begin
      @(posedge clk);
    end
    rst <= 1'b0;
    // Reset values before any write
    @(negedge clk);
    check_hex({NUM_DIGITS{SEG_OFF}}, hex);
    check_leds('0, ledr);
    check_read('0, readdata);
    for (int i = 0; i < NUM_DIGITS; i++) begin
      mdl_digit[i] = '0;
    end
    mdl_blank = '1;
    mdl_led   = '0;
    exp_rd    = '0;
    pend      = '0;
    // Directed table
    for (int i = 0; i < NUM_VECS; i++) begin
      apply_entry(VECTORS[i].op, VECTORS[i].addr, VECTORS[i].data, VECTORS[i].exp_read);
    end
    // Every glyph on every digit with the mask cleared by the table
    for (int d = 0; d < NUM_DIGITS; d++) begin
      for (int v = 0; v < 16; v++) begin
        apply_entry(OP_WRITE, ADDR_W'(d), DATA_W'(v), '0);
      end
    end
    // Random digit and mask writes
    for (int i = 0; i < NUM_RANDOM; i++) begin
      apply_entry(OP_WRITE, ADDR_W'($urandom % 7), DATA_W'($urandom), '0);
    end
    // Idle so the model is current before the sweep
    apply_entry(OP_IDLE, '0, '0, '0);
    for (int a = 0; a < 8; a++) begin
      apply_entry(OP_READ, ADDR_W'(a), '0, model_read(ADDR_W'(a)));
    end
    // Flush the last entries through the pin registers
    apply_entry(OP_IDLE, '0, '0, '0);
    apply_entry(OP_IDLE, '0, '0, '0);
    $display("Checks done, %0d errors", err_count);
    if (err_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+include
design/hex_pkg.sv
design/seg_decoder.sv
design/hex_regs.sv
design/hex_display_top.sv
verif/tb_hex_display.sv
